//--- Bender.yml
package:
  name: fetch_unit

sources:
  - logic/fetch_pkg.sv
  - logic/beat_counter.sv
  - logic/icache_array.sv
  - logic/refill_reader.sv
  - logic/fetch_control.sv
  - logic/fetch_unit.sv
  - target: test
    files:
      - test/fetch_tb.sv

//--- logic/beat_counter.sv
`timescale 1ns/1ns
`default_nettype none

module beat_counter import fetch_pkg::*; (
  input  wire logic                          clock,
  input  wire logic                          reset,
  input  wire logic                          clear,
  input  wire logic                          beat,
  output logic [$clog2(LINE_WORDS)-1:0]      index,
  output logic                               final_beat
);

  localparam int COUNT_BITS = $clog2(LINE_WORDS);

  // position of the next beat inside the line
  always_ff @(posedge clock) begin
    if (reset || clear) begin
      index <= '0;
    end else if (beat) begin
      if (final_beat) begin
        index <= '0;
      end else begin
        index <= index + 1'b1;
      end
    end
  end

  assign final_beat = (index == COUNT_BITS'(LINE_WORDS - 1));

  // clear wins over beat, so a beat taken at the start of a burst would be lost
  a_clear_without_beat: assert property (
    @(posedge clock) disable iff (reset)
    clear |-> !beat
  );

endmodule

`default_nettype wire

//--- logic/fetch_control.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_control import fetch_pkg::*; #(
  parameter logic [31:0] RESET_PC     = 32'h3000_0000,
  parameter logic [7:0]  UNCACHED_TOP = 8'h0f
) (
  input  wire logic         clock,
  input  wire logic         reset,
  input  wire logic         redirect,
  input  wire logic [31:0]  target,
  input  wire logic         flush,
  input  wire logic         inst_ready,
  input  wire logic         hit,
  input  wire logic [31:0]  hit_word,
  input  wire logic         fill_done,
  input  wire cache_line_t  fill_line,
  input  wire logic         fill_error,
  output fetch_addr_u       lookup_addr,
  output logic              install,
  output cache_line_t       install_line,
  output logic              cache_flush,
  output logic              fill_start,
  output fetch_addr_u       fill_addr,
  output logic              inst_valid,
  output fetch_out_t        inst
);

  fetch_state_e state;
  fetch_addr_u  pc;
  logic         cancelled;
  logic         uncached;
  logic         cache_hit;
  logic         slot_free;
  fetch_out_t   hit_out;
  fetch_out_t   fill_out;
  fetch_out_t   held;

  assign uncached  = (pc.raw[31:24] == UNCACHED_TOP);
  assign cache_hit = hit && !uncached;
  assign slot_free = !inst_valid || inst_ready;

  assign hit_out  = '{word: hit_word, pc: pc.raw, fault: 1'b0};
  assign fill_out = '{word: fill_line.data[pc.fields.word_sel], pc: pc.raw, fault: fill_error};

  assign lookup_addr  = pc;
  assign fill_addr    = pc;
  assign cache_flush  = flush;
  assign install_line = fill_line;

  // a miss is issued even while the output slot is full and pc only moves on delivery
  assign fill_start = (state == ST_LOOKUP) && !redirect && !cache_hit;

  assign install = (state == ST_REFILL) && fill_done && !cancelled && !redirect &&
                   !fill_error && !uncached;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= ST_LOOKUP;
      pc.raw     <= RESET_PC;
      inst_valid <= 1'b0;
      cancelled  <= 1'b0;
    end else if (redirect) begin
      pc.raw     <= target;
      inst_valid <= 1'b0;
      // the running burst still has to drain before the next one starts
      if (state == ST_REFILL && !fill_done) begin
        cancelled <= 1'b1;
      end else begin
        state     <= ST_LOOKUP;
        cancelled <= 1'b0;
      end
    end else begin
      if (inst_ready) begin
        inst_valid <= 1'b0;
      end
      case (state)
        ST_LOOKUP: begin
          if (fill_start) begin
            state <= ST_REFILL;
          end else if (slot_free) begin
            inst       <= hit_out;
            inst_valid <= 1'b1;
            pc.raw     <= pc.raw + 32'd4;
          end
        end
        ST_REFILL: begin
          if (fill_done) begin
            if (cancelled) begin
              cancelled <= 1'b0;
              state     <= ST_LOOKUP;
            end else if (slot_free) begin
              inst       <= fill_out;
              inst_valid <= 1'b1;
              pc.raw     <= pc.raw + 32'd4;
              state      <= ST_LOOKUP;
            end else begin
              held  <= fill_out;
              state <= ST_DELIVER;
            end
          end
        end
        ST_DELIVER: begin
          if (slot_free) begin
            inst       <= held;
            inst_valid <= 1'b1;
            pc.raw     <= pc.raw + 32'd4;
            state      <= ST_LOOKUP;
          end
        end
        default: state <= ST_LOOKUP;
      endcase
    end
  end

  a_inst_stable: assert property (
    @(posedge clock) disable iff (reset)
    inst_valid && !inst_ready && !redirect |=> inst_valid && $stable(inst)
  );

  // a finished refill always finds the controller still waiting for it
  a_done_in_refill: assert property (
    @(posedge clock) disable iff (reset)
    fill_done |-> (state == ST_REFILL)
  );

endmodule

`default_nettype wire

//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // direct-mapped cache of 16 lines, each line two 32-bit words
  localparam int INDEX_BITS  = 4;
  localparam int LINE_WORDS  = 2;
  localparam int OFFSET_BITS = 3;
  localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

  typedef struct packed {
    logic [TAG_BITS-1:0]   tag;
    logic [INDEX_BITS-1:0] index;
    logic                  word_sel;
    logic [1:0]            byte_off;
  } addr_fields_t;

  // the same fetch address, seen as a number or split for the cache lookup
  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t fields;
  } fetch_addr_u;

  typedef struct packed {
    logic                         valid;
    logic [TAG_BITS-1:0]          tag;
    logic [LINE_WORDS-1:0][31:0]  data;
  } cache_line_t;

  typedef struct packed {
    logic [31:0] word;
    logic [31:0] pc;
    logic        fault;
  } fetch_out_t;

  // len counts beats minus one, as on AXI
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
  } read_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
    logic        last;
  } read_beat_t;

  typedef enum logic [1:0] {
    ST_LOOKUP,
    ST_REFILL,
    ST_DELIVER
  } fetch_state_e;

endpackage

`default_nettype wire

//--- logic/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import fetch_pkg::*; #(
  parameter logic [31:0] RESET_PC     = 32'h3000_0000,
  parameter logic [7:0]  UNCACHED_TOP = 8'h0f
) (
  input  wire logic         clock,
  input  wire logic         reset,
  input  wire logic         redirect,
  input  wire logic [31:0]  target,
  input  wire logic         flush,
  output logic              inst_valid,
  output fetch_out_t        inst,
  input  wire logic         inst_ready,
  output logic              arvalid,
  output read_req_t         ar,
  input  wire logic         arready,
  input  wire logic         rvalid,
  input  wire read_beat_t   r,
  output logic              rready
);

  fetch_addr_u lookup_addr;
  fetch_addr_u fill_addr;
  logic        hit;
  logic [31:0] hit_word;
  logic        install;
  cache_line_t install_line;
  logic        cache_flush;
  logic        fill_start;
  logic        fill_done;
  cache_line_t fill_line;
  logic        fill_error;

  fetch_control #(
    .RESET_PC     (RESET_PC),
    .UNCACHED_TOP (UNCACHED_TOP)
  ) i_fetch_control (
    .clock        (clock),
    .reset        (reset),
    .redirect     (redirect),
    .target       (target),
    .flush        (flush),
    .inst_ready   (inst_ready),
    .hit          (hit),
    .hit_word     (hit_word),
    .fill_done    (fill_done),
    .fill_line    (fill_line),
    .fill_error   (fill_error),
    .lookup_addr  (lookup_addr),
    .install      (install),
    .install_line (install_line),
    .cache_flush  (cache_flush),
    .fill_start   (fill_start),
    .fill_addr    (fill_addr),
    .inst_valid   (inst_valid),
    .inst         (inst)
  );

  icache_array i_icache_array (
    .clock        (clock),
    .reset        (reset),
    .lookup_addr  (lookup_addr),
    .install      (install),
    .install_line (install_line),
    .cache_flush  (cache_flush),
    .hit          (hit),
    .hit_word     (hit_word)
  );

  refill_reader i_refill_reader (
    .clock      (clock),
    .reset      (reset),
    .fill_start (fill_start),
    .fill_addr  (fill_addr),
    .arvalid    (arvalid),
    .ar         (ar),
    .arready    (arready),
    .rvalid     (rvalid),
    .r          (r),
    .rready     (rready),
    .fill_done  (fill_done),
    .fill_line  (fill_line),
    .fill_error (fill_error)
  );

endmodule

`default_nettype wire

//--- logic/icache_array.sv
`timescale 1ns/1ns
`default_nettype none

module icache_array import fetch_pkg::*; (
  input  wire logic         clock,
  input  wire logic         reset,
  input  wire fetch_addr_u  lookup_addr,
  input  wire logic         install,
  input  wire cache_line_t  install_line,
  input  wire logic         cache_flush,
  output logic              hit,
  output logic [31:0]       hit_word
);

  localparam int NUM_LINES = 2 ** INDEX_BITS;

  logic [NUM_LINES-1:0]        line_valid;
  logic [TAG_BITS-1:0]         tags [NUM_LINES];
  logic [LINE_WORDS-1:0][31:0] lines [NUM_LINES];

  logic [INDEX_BITS-1:0]       index;
  logic [TAG_BITS-1:0]         stored_tag;
  logic [LINE_WORDS-1:0][31:0] stored_line;

  assign index       = lookup_addr.fields.index;
  assign stored_tag  = tags[index];
  assign stored_line = lines[index];

  assign hit      = line_valid[index] && (stored_tag == lookup_addr.fields.tag);
  assign hit_word = stored_line[lookup_addr.fields.word_sel];

  // a line installed in the same cycle as a flush survives it
  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else begin
      if (cache_flush) begin
        line_valid <= '0;
      end
      if (install) begin
        line_valid[index] <= install_line.valid;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (install) begin
      tags[index]  <= install_line.tag;
      lines[index] <= install_line.data;
    end
  end

  // an installed line answers the same address on the next lookup
  a_install_then_hit: assert property (
    @(posedge clock) disable iff (reset)
    install && install_line.valid && !$changed(lookup_addr) ##1
      $stable(lookup_addr) |-> hit
  );

endmodule

`default_nettype wire

//--- logic/refill_reader.sv
`timescale 1ns/1ns
`default_nettype none

module refill_reader import fetch_pkg::*; (
  input  wire logic         clock,
  input  wire logic         reset,
  input  wire logic         fill_start,
  input  wire fetch_addr_u  fill_addr,
  output logic              arvalid,
  output read_req_t         ar,
  input  wire logic         arready,
  input  wire logic         rvalid,
  input  wire read_beat_t   r,
  output logic              rready,
  output logic              fill_done,
  output cache_line_t       fill_line,
  output logic              fill_error
);

  logic                           busy;
  logic                           beat;
  logic                           final_beat;
  logic [$clog2(LINE_WORDS)-1:0]  beat_index;
  fetch_addr_u                    line_addr;
  logic [LINE_WORDS-1:0][31:0]    line_data;

  assign beat = rvalid && rready;

  beat_counter i_beat_counter (
    .clock      (clock),
    .reset      (reset),
    .clear      (fill_start),
    .beat       (beat),
    .index      (beat_index),
    .final_beat (final_beat)
  );

  assign ar.addr = line_addr.raw;
  assign ar.len  = 8'(LINE_WORDS - 1);

  assign fill_line.valid = 1'b1;
  assign fill_line.tag   = line_addr.fields.tag;
  assign fill_line.data  = line_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy       <= 1'b0;
      arvalid    <= 1'b0;
      rready     <= 1'b0;
      fill_done  <= 1'b0;
      fill_error <= 1'b0;
    end else begin
      fill_done <= 1'b0;
      if (fill_start) begin
        busy       <= 1'b1;
        arvalid    <= 1'b1;
        fill_error <= 1'b0;
      end
      if (arvalid && arready) begin
        arvalid <= 1'b0;
        rready  <= 1'b1;
      end
      if (beat) begin
        // a bad response or a last flag out of step with the count faults the line
        if (r.resp != 2'b00 || r.last != final_beat) begin
          fill_error <= 1'b1;
        end
        if (r.last) begin
          rready    <= 1'b0;
          busy      <= 1'b0;
          fill_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill_start) begin
      line_addr.raw <= {fill_addr.raw[31:OFFSET_BITS], OFFSET_BITS'(0)};
    end
    if (beat) begin
      line_data[beat_index] <= r.data;
    end
  end

  a_no_start_while_busy: assert property (
    @(posedge clock) disable iff (reset)
    fill_start |-> !busy
  );

endmodule

`default_nettype wire

//--- test/fetch_stimulus.txt
window 30400000 30400008
fetch none     0 100 31 16
fetch 30000000 0 100 31 0
fetch 30000000 0  60 31 0
fetch 30000100 0  40 15 8
fetch 30000100 1 100 15 8
fetch 0f000000 0 100  6 6
fetch 0f000000 0 100  6 7
fetch 30400000 0 100  3 4
fetch 30400000 0 100  3 2
fetch 30000000 0  50 31 16
fetch 30000000 0 100 31 0

//--- test/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

  localparam logic [31:0] RESET_PC = 32'h3000_0000;
  localparam logic [31:0] WORD_KEY = 32'h5a5a_0000;

  logic        clock;
  logic        reset;
  logic        redirect;
  logic [31:0] target;
  logic        flush;
  logic        inst_valid;
  fetch_out_t  inst;
  logic        inst_ready;
  logic        arvalid;
  read_req_t   ar;
  logic        arready = 1'b0;
  logic        rvalid = 1'b0;
  read_beat_t  r = '0;
  logic        rready;

  // records read from the stimulus file
  logic [31:0] rec_target [$];
  bit          rec_jump [$];
  bit          rec_flush [$];
  int          rec_duty [$];
  int          rec_words [$];
  int          rec_count [$];
  logic [31:0] err_lo;
  logic [31:0] err_hi;

  int          handshakes = 0;
  int          cycles = 0;
  int          cycle_limit = 1000000;

  logic [31:0] burst_addr;
  int          burst_len;
  int          beat_no;
  bit          in_burst;
  int          ar_delay;
  int          r_delay;

  fetch_unit i_dut (
    .clock      (clock),
    .reset      (reset),
    .redirect   (redirect),
    .target     (target),
    .flush      (flush),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready),
    .arvalid    (arvalid),
    .ar         (ar),
    .arready    (arready),
    .rvalid     (rvalid),
    .r          (r),
    .rready     (rready)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_fetch(input string name, input fetch_out_t got, input fetch_out_t exp);
    if (got.word !== exp.word) begin
      report_failure($sformatf("error at %0t ns: %s.word got %h expected %h",
                               $time, name, got.word, exp.word));
    end
    if (got.pc !== exp.pc) begin
      report_failure($sformatf("error at %0t ns: %s.pc got %h expected %h",
                               $time, name, got.pc, exp.pc));
    end
    if (got.fault !== exp.fault) begin
      report_failure($sformatf("error at %0t ns: %s.fault got %b expected %b",
                               $time, name, got.fault, exp.fault));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("error at %0t ns: %s got %0d expected %0d",
                               $time, name, got, exp));
    end
  endtask

  // a line faults when any of its two words lies in the error window
  function automatic fetch_out_t expected_fetch(input logic [31:0] pc);
    logic [31:0] base;
    fetch_out_t  exp;
    base      = {pc[31:3], 3'b000};
    exp.word  = pc ^ WORD_KEY;
    exp.pc    = pc;
    exp.fault = (base < err_hi) && (base + 32'd8 > err_lo);
    return exp;
  endfunction

  function automatic read_beat_t memory_beat(input logic [31:0] addr, input bit last);
    read_beat_t beat;
    beat.data = addr ^ WORD_KEY;
    beat.resp = (addr >= err_lo && addr < err_hi) ? 2'b10 : 2'b00;
    beat.last = last;
    return beat;
  endfunction

  // memory slave with random address and data delays of 0 to 3 cycles
  always @(posedge clock) begin
    if (reset) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      in_burst <= 1'b0;
      ar_delay <= $urandom % 4;
      r_delay  <= 0;
    end else begin
      if (arvalid && arready) begin
        handshakes <= handshakes + 1;
        arready    <= 1'b0;
        in_burst   <= 1'b1;
        burst_addr <= ar.addr;
        burst_len  <= int'(ar.len);
        beat_no    <= 0;
        r_delay    <= $urandom % 4;
        ar_delay   <= $urandom % 4;
      end else if (arvalid) begin
        if (ar_delay == 0) begin
          arready <= 1'b1;
        end else begin
          ar_delay <= ar_delay - 1;
        end
      end
      if (rvalid && rready) begin
        rvalid  <= 1'b0;
        beat_no <= beat_no + 1;
        r_delay <= $urandom % 4;
        if (r.last) begin
          in_burst <= 1'b0;
        end
      end else if (in_burst && !rvalid) begin
        if (r_delay == 0) begin
          rvalid <= 1'b1;
          r      <= memory_beat(burst_addr + 32'(4 * beat_no), beat_no == burst_len);
        end else begin
          r_delay <= r_delay - 1;
        end
      end
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      report_failure("the fetch stalled and the run reached its cycle limit");
    end
  end

  task automatic read_stimulus();
    int          fd;
    int          n;
    int          total;
    string       kind;
    string       tstr;
    logic [31:0] t;
    int          fl;
    int          duty;
    int          words;
    int          count;
    total = 0;
    fd = $fopen("test/fetch_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("the stimulus file could not be opened");
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", kind);
      if (n != 1) begin
        break;
      end
      if (kind == "window") begin
        n = $fscanf(fd, "%h %h", err_lo, err_hi);
      end else if (kind == "fetch") begin
        n = $fscanf(fd, "%s %d %d %d %d", tstr, fl, duty, words, count);
        t = '0;
        if (tstr != "none") begin
          n = $sscanf(tstr, "%h", t);
        end
        rec_jump.push_back(tstr != "none");
        rec_target.push_back(t);
        rec_flush.push_back(fl != 0);
        rec_duty.push_back(duty);
        rec_words.push_back(words);
        rec_count.push_back(count);
        total += words;
      end else begin
        report_failure($sformatf("the stimulus file holds an unknown record %s", kind));
      end
    end
    $fclose(fd);
    cycle_limit = 64 * total + 200;
  endtask

  // starts on the edge where the previous record took its last word
  task automatic run_record(input int idx);
    logic [31:0] pc;
    int          accepted;
    int          start_count;
    bit          held_valid;
    fetch_out_t  held;
    pc          = rec_jump[idx] ? rec_target[idx] : RESET_PC;
    accepted    = 0;
    held_valid  = 1'b0;
    start_count = handshakes;
    if (rec_jump[idx]) begin
      redirect   <= 1'b1;
      target     <= rec_target[idx];
      flush      <= rec_flush[idx];
      inst_ready <= 1'b0;
      @(posedge clock);
      redirect <= 1'b0;
      flush    <= 1'b0;
    end
    inst_ready <= ($urandom % 100) < rec_duty[idx];
    while (accepted < rec_words[idx]) begin
      @(posedge clock);
      if (held_valid) begin
        if (!inst_valid) begin
          report_failure("inst_valid dropped while decode was stalled");
        end
        check_fetch("inst", inst, held);
      end
      held_valid = inst_valid && !inst_ready;
      held       = inst;
      if (inst_valid && inst_ready) begin
        check_fetch("inst", inst, expected_fetch(pc));
        pc += 32'd4;
        accepted++;
      end
      if (accepted < rec_words[idx]) begin
        inst_ready <= ($urandom % 100) < rec_duty[idx];
      end
    end
    check_count("ar handshakes", handshakes - start_count, rec_count[idx]);
  endtask

  initial begin
    void'($urandom(32'hc170_6a40));
    reset      = 1'b1;
    redirect   = 1'b0;
    target     = '0;
    flush      = 1'b0;
    inst_ready = 1'b0;
    read_stimulus();
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < rec_words.size(); i++) begin
      run_record(i);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/fetch_pkg.sv
logic/beat_counter.sv
logic/icache_array.sv
logic/refill_reader.sv
logic/fetch_control.sv
logic/fetch_unit.sv
test/fetch_tb.sv
